//--- common/monitor_params.svh
`ifndef MONITOR_PARAMS_SVH
`define MONITOR_PARAMS_SVH

// Stable cycles before a key level is accepted, kept short for simulation
`define DBC_CYCLES 16

// Clock cycles per UART bit
`define UART_CLKS_PER_BIT 8

`define NUM_DIGITS 6

`endif

//--- common/monitor_pkg.sv
`include "monitor_params.svh"

package monitor_pkg;

  // ==========================================================================
  // Key events
  // ==========================================================================

  // Debounced level plus one-cycle edge pulses
  typedef struct packed {
    logic level;
    logic rise;
    logic fall;
  } key_event_t;

  // ==========================================================================
  // UART bytes
  // ==========================================================================

  // Host command: high nibble picks the digit, low nibble is its value
  typedef struct packed {
    logic [3:0] digit_idx;
    logic [3:0] value;
  } uart_cmd_t;

  // Same received byte, seen as echo data or as a command
  typedef union packed {
    logic [7:0] raw;
    uart_cmd_t  cmd;
  } uart_byte_u;

  // Display, digit 0 in the low nibble
  typedef logic [`NUM_DIGITS-1:0][3:0] hex_digits_t;

  // Active-low segments, bit 6 is segment g
  typedef logic [6:0] seg7_t;

endpackage

//--- design/key_debouncer.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module key_debouncer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    key,
  output monitor_pkg::key_event_t evt
);

  localparam int CW = $clog2(`DBC_CYCLES);
  localparam logic [CW-1:0] CNT_LAST = CW'(`DBC_CYCLES - 1);

  logic [1:0]    sync_q;
  logic          level_q;
  logic          rise_q;
  logic          fall_q;
  logic [CW-1:0] cnt_q;

  // Keys idle high, so everything comes out of reset at 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q  <= 2'b11;
      level_q <= 1'b1;
      rise_q  <= 1'b0;
      fall_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      sync_q <= {sync_q[0], key};
      rise_q <= 1'b0;
      fall_q <= 1'b0;
      if (sync_q[1] == level_q) begin
        // Any bounce back restarts the window
        cnt_q <= '0;
      end else if (cnt_q == CNT_LAST) begin
        cnt_q   <= '0;
        level_q <= sync_q[1];
        rise_q  <= sync_q[1];
        fall_q  <= ~sync_q[1];
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    evt.level = level_q;
    evt.rise  = rise_q;
    evt.fall  = fall_q;
  end

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module uart_rx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rxd,
  output monitor_pkg::uart_byte_u rx_byte,
  output logic                    rx_valid
);

  localparam int CW = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [CW-1:0] BIT_LAST  = CW'(`UART_CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_LAST = CW'(`UART_CLKS_PER_BIT / 2 - 1);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic [1:0]    rxd_sync_q;
  logic          rxd_prev_q;
  logic [1:0]    state_q;
  logic [CW-1:0] cnt_q;
  logic [2:0]    bit_q;
  logic [7:0]    shift_q;
  logic          valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rxd_sync_q <= 2'b11;
      rxd_prev_q <= 1'b1;
      state_q    <= S_IDLE;
      cnt_q      <= '0;
      bit_q      <= '0;
      valid_q    <= 1'b0;
    end else begin
      rxd_sync_q <= {rxd_sync_q[0], rxd};
      rxd_prev_q <= rxd_sync_q[1];
      valid_q    <= 1'b0;
      cnt_q      <= cnt_q + 1'b1;
      case (state_q)
        S_IDLE: begin
          // Falling edge opens a frame
          if (rxd_prev_q && !rxd_sync_q[1]) begin
            state_q <= S_START;
            cnt_q   <= '0;
          end
        end
        S_START: begin
          if (cnt_q == HALF_LAST) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rxd_sync_q[1] ? S_IDLE : S_DATA;
          end
        end
        S_DATA: begin
          if (cnt_q == BIT_LAST) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= S_STOP;
          end
        end
        default: begin
          // Bad stop bit drops the frame
          if (cnt_q == BIT_LAST) begin
            valid_q <= rxd_sync_q[1];
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Data bits, LSB first
  always_ff @(posedge clk) begin
    if (state_q == S_DATA && cnt_q == BIT_LAST) begin
      shift_q <= {rxd_sync_q[1], shift_q[7:1]};
    end
  end

  always_comb begin
    rx_byte.raw = shift_q;
    rx_valid    = valid_q;
  end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_byte,
  input  logic       tx_start,
  output logic       txd,
  output logic       tx_busy
);

  localparam int CW = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [CW-1:0] BIT_LAST = CW'(`UART_CLKS_PER_BIT - 1);

  // Stop, data, start, with the start bit leaving first
  logic [9:0]    frame_q;
  logic [CW-1:0] cnt_q;
  logic [3:0]    bit_q;
  logic          busy_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_q <= '1;
      cnt_q   <= '0;
      bit_q   <= '0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (tx_start) begin
        frame_q <= {1'b1, tx_byte, 1'b0};
        cnt_q   <= '0;
        bit_q   <= '0;
        busy_q  <= 1'b1;
      end
    end else if (cnt_q == BIT_LAST) begin
      cnt_q <= '0;
      // Ones shift in behind, so the line rests high when done
      frame_q <= {1'b1, frame_q[9:1]};
      bit_q   <= bit_q + 1'b1;
      if (bit_q == 4'd9) busy_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign txd     = frame_q[0];
  assign tx_busy = busy_q;

endmodule

//--- design/hex_display.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module hex_display (
  input  logic                     clk,
  input  logic                     rst_n,
  input  monitor_pkg::hex_digits_t digits,
  output monitor_pkg::seg7_t       hex0,
  output monitor_pkg::seg7_t       hex1,
  output monitor_pkg::seg7_t       hex2,
  output monitor_pkg::seg7_t       hex3,
  output monitor_pkg::seg7_t       hex4,
  output monitor_pkg::seg7_t       hex5
);

  localparam monitor_pkg::seg7_t SEG_ZERO = 7'h40;

  function automatic monitor_pkg::seg7_t seg_decode(input logic [3:0] d);
    monitor_pkg::seg7_t s;
    case (d)
      4'h0:    s = 7'h40;
      4'h1:    s = 7'h79;
      4'h2:    s = 7'h24;
      4'h3:    s = 7'h30;
      4'h4:    s = 7'h19;
      4'h5:    s = 7'h12;
      4'h6:    s = 7'h02;
      4'h7:    s = 7'h78;
      4'h8:    s = 7'h00;
      4'h9:    s = 7'h10;
      4'ha:    s = 7'h08;
      4'hb:    s = 7'h03;
      4'hc:    s = 7'h46;
      4'hd:    s = 7'h21;
      4'he:    s = 7'h06;
      default: s = 7'h0e;
    endcase
    return s;
  endfunction

  monitor_pkg::seg7_t seg_q [`NUM_DIGITS];

  // One register stage after the decode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_DIGITS; i++) seg_q[i] <= SEG_ZERO;
    end else begin
      for (int i = 0; i < `NUM_DIGITS; i++) seg_q[i] <= seg_decode(digits[i]);
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule

//--- design/monitor_ctrl.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module monitor_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  monitor_pkg::key_event_t  go_evt,
  input  monitor_pkg::key_event_t  clr_evt,
  input  logic [9:0]               sw,
  input  monitor_pkg::uart_byte_u  rx_byte,
  input  logic                     rx_valid,
  input  logic                     cts,
  input  logic                     tx_busy,
  output logic [7:0]               tx_byte,
  output logic                     tx_start,
  output logic                     rts,
  output monitor_pkg::hex_digits_t digits
);

  monitor_pkg::hex_digits_t digits_q;
  logic       slot_full_q;
  logic [7:0] slot_data_q;
  logic [1:0] cts_sync_q;
  logic       go_take;
  logic       rx_hit;

  // A go press only counts while the slot is free
  assign go_take = go_evt.fall && !slot_full_q;
  assign rx_hit  = rx_valid && (rx_byte.cmd.digit_idx < 4'(`NUM_DIGITS));

  // ==========================================================================
  // Digit register, clear beats receive beats go
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digits_q <= '0;
    end else if (clr_evt.fall) begin
      digits_q <= '0;
    end else if (rx_valid) begin
      if (rx_hit) digits_q[rx_byte.cmd.digit_idx[2:0]] <= rx_byte.cmd.value;
    end else if (go_take) begin
      digits_q <= monitor_pkg::hex_digits_t'({12'h000, 2'b00, sw});
    end
  end

  // ==========================================================================
  // Pending-transmit slot
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_full_q <= 1'b0;
      cts_sync_q  <= 2'b11;
    end else begin
      cts_sync_q <= {cts_sync_q[0], cts};
      // New byte overwrites, even in the cycle the old one leaves
      if (rx_valid || go_take) slot_full_q <= 1'b1;
      else if (tx_start) slot_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) slot_data_q <= rx_byte.raw;
    else if (go_take) slot_data_q <= sw[7:0];
  end

  // Host holds us off with cts high
  assign tx_start = slot_full_q && !tx_busy && !cts_sync_q[1];
  assign tx_byte  = slot_data_q;
  assign rts      = slot_full_q;
  assign digits   = digits_q;

endmodule

//--- design/board_monitor_top.sv
`timescale 1ns/1ps

module board_monitor_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [1:0]         key,
  input  logic [9:0]         sw,
  input  logic               uart_rx,
  input  logic               uart_cts,
  output logic               uart_tx,
  output logic               uart_rts,
  output monitor_pkg::seg7_t hex0,
  output monitor_pkg::seg7_t hex1,
  output monitor_pkg::seg7_t hex2,
  output monitor_pkg::seg7_t hex3,
  output monitor_pkg::seg7_t hex4,
  output monitor_pkg::seg7_t hex5
);

  monitor_pkg::key_event_t  key_evt [2];
  monitor_pkg::uart_byte_u  rx_byte;
  monitor_pkg::hex_digits_t digits;
  logic                     rx_valid;
  logic [7:0]               tx_byte;
  logic                     tx_start;
  logic                     tx_busy;

  // Key 0 is go, key 1 is clear
  for (genvar i = 0; i < 2; i++) begin : g_key_dbc
    key_debouncer u_key_debouncer (
      .clk   (clk),
      .rst_n (rst_n),
      .key   (key[i]),
      .evt   (key_evt[i])
    );
  end

  uart_rx u_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rxd      (uart_rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .txd      (uart_tx),
    .tx_busy  (tx_busy)
  );

  monitor_ctrl u_monitor_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .go_evt   (key_evt[0]),
    .clr_evt  (key_evt[1]),
    .sw       (sw),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .cts      (uart_cts),
    .tx_busy  (tx_busy),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .rts      (uart_rts),
    .digits   (digits)
  );

  hex_display u_hex_display (
    .clk    (clk),
    .rst_n  (rst_n),
    .digits (digits),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5)
  );

endmodule

//--- sim/board_monitor_asserts.sv
`timescale 1ns/1ps

module board_monitor_asserts (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    tx_start,
  input logic                    tx_busy,
  input logic                    txd,
  input logic                    rts,
  input monitor_pkg::key_event_t go_evt,
  input monitor_pkg::key_event_t clr_evt
);

  // Transmitter handshake
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
    else $error("tx_start raised while the transmitter is busy");

  a_line_idle: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> txd)
    else $error("uart_tx low while the transmitter is idle");

  // Edge pulses are exclusive
  a_go_edges: assert property (@(posedge clk) disable iff (!rst_n) !(go_evt.rise && go_evt.fall))
    else $error("go key rise and fall in the same cycle");

  a_clr_edges: assert property (@(posedge clk) disable iff (!rst_n)
                                !(clr_evt.rise && clr_evt.fall))
    else $error("clear key rise and fall in the same cycle");

  a_rts_reset: assert property (@(posedge clk) $rose(rst_n) |-> !rts)
    else $error("uart_rts high in the first cycle after reset");

endmodule

bind board_monitor_top board_monitor_asserts u_board_monitor_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx_start (tx_start),
  .tx_busy  (tx_busy),
  .txd      (uart_tx),
  .rts      (uart_rts),
  .go_evt   (key_evt[0]),
  .clr_evt  (key_evt[1])
);

//--- sim/board_monitor_tb.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module board_monitor_tb;

  localparam int CPB          = `UART_CLKS_PER_BIT;
  localparam int DBC          = `DBC_CYCLES;
  localparam int RX_TIMEOUT   = 20 * CPB + 4 * DBC;
  localparam int DISP_TIMEOUT = DBC + 12;
  localparam int HOLD_WINDOW  = 40 * CPB;
  localparam int WATCHDOG     = 50000;
  localparam logic [31:0] LFSR_SEED = 32'h28aa6e32;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  // Hex digit to active-low segments with segment g on bit 6
  localparam monitor_pkg::seg7_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  logic                     clk;
  logic                     rst_n;
  logic [1:0]               key;
  logic [9:0]               sw;
  logic                     uart_rx;
  logic                     uart_cts;
  logic                     uart_tx;
  logic                     uart_rts;
  monitor_pkg::seg7_t       hex_out [`NUM_DIGITS];
  monitor_pkg::hex_digits_t exp_digits;
  logic [31:0]              lfsr_q;

  board_monitor_top u_board_monitor_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .key      (key),
    .sw       (sw),
    .uart_rx  (uart_rx),
    .uart_cts (uart_cts),
    .uart_tx  (uart_tx),
    .uart_rts (uart_rts),
    .hex0     (hex_out[0]),
    .hex1     (hex_out[1]),
    .hex2     (hex_out[2]),
    .hex3     (hex_out[3]),
    .hex4     (hex_out[4]),
    .hex5     (hex_out[5])
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==========================================================================
  // Reporting and checks
  // ==========================================================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Run stopped after a failed check");
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_hex(input monitor_pkg::seg7_t got, input monitor_pkg::seg7_t exp,
                           input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic display_matches();
    logic same;
    same = 1'b1;
    for (int i = 0; i < `NUM_DIGITS; i++) begin
      if (hex_out[i] !== SEG_TABLE[exp_digits[i]]) same = 1'b0;
    end
    return same;
  endfunction

  // Waits for the display model, then checks every digit
  task automatic wait_display(input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!display_matches() && waited < DISP_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    for (int i = 0; i < `NUM_DIGITS; i++) begin
      check_hex(hex_out[i], SEG_TABLE[exp_digits[i]], $sformatf("%s hex%0d", what, i));
    end
  endtask

  // Nothing may move on the display or the serial lines
  task automatic check_quiet(input int cycles, input string what);
    repeat (cycles) begin
      @(negedge clk);
      check_level(uart_tx, 1'b1, {what, " uart_tx"});
      check_level(uart_rts, 1'b0, {what, " uart_rts"});
      for (int i = 0; i < `NUM_DIGITS; i++) begin
        check_hex(hex_out[i], SEG_TABLE[exp_digits[i]], $sformatf("%s hex%0d", what, i));
      end
    end
  endtask

  // ==========================================================================
  // Host UART model and keys
  // ==========================================================================
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (CPB - 1) @(posedge clk);
    end
  endtask

  // Samples each bit near its middle
  task automatic recv_byte(output logic [7:0] b);
    logic [7:0] data;
    int         waited;
    waited = 0;
    @(negedge clk);
    while (uart_tx !== 1'b0) begin
      if (waited == RX_TIMEOUT) abort_run("Timeout waiting for a start bit on uart_tx");
      waited++;
      @(negedge clk);
    end
    repeat (CPB / 2) @(negedge clk);
    check_level(uart_tx, 1'b0, "start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(negedge clk);
      data[i] = uart_tx;
    end
    repeat (CPB) @(negedge clk);
    check_level(uart_tx, 1'b1, "stop bit");
    b = data;
  endtask

  task automatic press_key(input int idx);
    @(posedge clk);
    key[idx] <= 1'b0;
    wait_display($sformatf("key %0d press", idx));
    @(posedge clk);
    key[idx] <= 1'b1;
    // Let the release pass the debouncer
    repeat (DBC + 8) @(posedge clk);
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic test_reset();
    exp_digits = '0;
    check_quiet(4, "after reset");
  endtask

  task automatic test_go_key();
    logic [31:0] r;
    logic [7:0]  got;
    r = rand_bits(10);
    @(posedge clk);
    sw <= r[9:0];
    exp_digits = '0;
    exp_digits[2:0] = {2'b00, r[9:0]};
    fork
      press_key(0);
      recv_byte(got);
    join
    check_byte(got, r[7:0], "go byte");
    // Short glitch on go
    @(posedge clk);
    key[0] <= 1'b0;
    repeat (DBC / 2) @(posedge clk);
    key[0] <= 1'b1;
    check_quiet(3 * DBC, "go glitch");
  endtask

  task automatic test_digit_write();
    logic [3:0] idx;
    logic [3:0] val;
    logic [7:0] got;
    for (int n = 0; n < 8; n++) begin
      idx = 4'(rand_bits(3) % 6);
      val = 4'(rand_bits(4));
      exp_digits[idx] = val;
      fork
        send_byte({idx, val});
        recv_byte(got);
      join
      check_byte(got, {idx, val}, "digit write echo");
      wait_display("digit write");
    end
  endtask

  task automatic test_out_of_range();
    logic [7:0] b;
    logic [7:0] got;
    for (int idx = 6; idx < 16; idx++) begin
      b = {4'(idx), 4'(rand_bits(4))};
      fork
        send_byte(b);
        recv_byte(got);
      join
      check_byte(got, b, "out-of-range echo");
      wait_display("out-of-range");
    end
  endtask

  task automatic test_flow_control();
    logic [7:0] b;
    logic [7:0] got;
    int         waited;
    b = {4'd3, 4'(rand_bits(4))};
    exp_digits[3] = b[3:0];
    @(posedge clk);
    uart_cts <= 1'b1;
    send_byte(b);
    waited = 0;
    @(negedge clk);
    while (uart_rts !== 1'b1) begin
      if (waited == RX_TIMEOUT) abort_run("Timeout waiting for uart_rts to rise");
      waited++;
      @(negedge clk);
    end
    repeat (HOLD_WINDOW) begin
      @(negedge clk);
      check_level(uart_rts, 1'b1, "held uart_rts");
      check_level(uart_tx, 1'b1, "held uart_tx");
    end
    @(posedge clk);
    uart_cts <= 1'b0;
    recv_byte(got);
    check_byte(got, b, "released echo");
    check_level(uart_rts, 1'b0, "uart_rts after release");
    wait_display("flow control");
  endtask

  task automatic test_clear_key();
    exp_digits = '0;
    press_key(1);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    rst_n    = 1'b0;
    key      = 2'b11;
    sw       = '0;
    uart_rx  = 1'b1;
    uart_cts = 1'b0;
    lfsr_q   = LFSR_SEED;
    exp_digits = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_go_key();
    test_digit_write();
    test_out_of_range();
    test_flow_control();
    test_clear_key();
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    abort_run("Simulation did not finish within the cycle limit");
  end

endmodule

//--- build.f
+incdir+common
common/monitor_pkg.sv
design/key_debouncer.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/hex_display.sv
design/monitor_ctrl.sv
design/board_monitor_top.sv
sim/board_monitor_asserts.sv
sim/board_monitor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the board monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module board_monitor_tb \
  -o board_monitor_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/board_monitor_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
